// ==== include/hist_defs.svh ====
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// histogram geometry, all pixels share one RAM
`define PIXEL_NUM 4
`define BIN_NUM   16
`define COUNT_W   8                              // bits per bin count

`define ACQ_LEN   200                            // samples per acquisition

// derived widths and sizes
`define PIX_W     ($clog2(`PIXEL_NUM))
`define BIN_W     ($clog2(`BIN_NUM))
`define ADDR_W    (`PIX_W + `BIN_W)              // one word per pixel/bin pair
`define RAM_WORDS (`PIXEL_NUM * `BIN_NUM)
`define ACQ_W     ($clog2(`ACQ_LEN))             // wide enough for the sample count

`endif

// ==== src/histDataPkg.sv ====
`include "hist_defs.svh"

package histDataPkg;

    typedef logic [`BIN_W-1:0] binIdx_t;         // time bin inside one pixel histogram
    typedef logic [`PIX_W-1:0] pixIdx_t;

    // detector sample as it arrives, pixel in the upper bits
    typedef struct packed {
        pixIdx_t pix;
        binIdx_t bin;
    } sample_t;

    // the pixel/bin split lines up with the flat word index,
    // so a sample is directly a RAM address
    typedef union packed {
        logic [`ADDR_W-1:0] flat;                // clear sweep and readout
        sample_t            pb;                  // accumulator view
    } ramAddr_u;

    typedef logic [`COUNT_W-1:0] count_t;

    typedef struct packed {
        logic     en;
        ramAddr_u addr;
        count_t   data;
    } ramWr_t;

endpackage

// ==== src/histCtrlPkg.sv ====
package histCtrlPkg;

    typedef enum logic [2:0] {
        CLEAR = 3'd0,                            // zeroing the RAM after reset
        IDLE  = 3'd1,                            // readout allowed
        ACQ   = 3'd2,
        DRAIN = 3'd3,                            // last increments still in flight
        DONE  = 3'd4
    } histState_t;

    // controller to datapath
    typedef struct packed {
        logic accept;                            // samples counted this cycle
        logic clearEn;                           // clear write this cycle
        logic rdGrant;                           // readout owns the read port
    } histCtrl_t;

endpackage

// ==== src/binRam.sv ====
`timescale 1ns/10ps
`include "hist_defs.svh"

module binRam import histDataPkg::*; (
    input  logic     clk,
    input  ramWr_t   wr,
    input  ramAddr_u rdAddr,
    output count_t   rdData
);

    count_t mem [`RAM_WORDS];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr.flat] <= wr.data;
        end
    end

    // same-address read in a write cycle sees the old word
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr.flat];
    end

endmodule

// ==== src/sampleCounter.sv ====
`timescale 1ns/10ps

module sampleCounter #(
    parameter int Width    = 8,
    parameter int Terminal = 200
) (
    input  logic             clk,
    input  logic             res,
    input  logic             load,               // back to zero, wins over enable
    input  logic             enable,
    output logic [Width-1:0] value,
    output logic             last
);

    localparam logic [Width-1:0] LastValue = Width'(Terminal - 1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            value <= '0;
        end else if (load) begin
            value <= '0;
        end else if (enable) begin
            value <= value + 1'b1;
        end
    end

    assign last = (value == LastValue);          // next step reaches Terminal

endmodule

// ==== src/histAccum.sv ====
`timescale 1ns/10ps
`include "hist_defs.svh"

module histAccum import histDataPkg::*, histCtrlPkg::*; (
    input  logic               clk,
    input  logic               res,
    input  histCtrl_t          ctrl,
    input  logic               sampleValid,
    input  sample_t            sample,
    input  logic [`ADDR_W-1:0] clearAddr,
    input  logic               rdEn,
    input  ramAddr_u           rdAddr,
    output ramAddr_u           ramRdAddr,
    input  count_t             ramRdData,
    output ramWr_t             wr,
    output logic               accepted
);

    ramAddr_u sampleAddr;                        // address of the incoming sample
    logic     s1Valid;                           // read data returning this cycle
    ramAddr_u s1Addr;
    ramWr_t   wrQ;                               // write stage
    ramWr_t   prevWr;                            // write that collided with the s1 read
    count_t   base;
    count_t   incCount;
    ramWr_t   wrNext;

    assign accepted = ctrl.accept & sampleValid;

    assign sampleAddr.pb = sample;

    // readout borrows the read port only in idle
    assign ramRdAddr = (ctrl.rdGrant && rdEn) ? rdAddr : sampleAddr;

    // read issue stage
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= accepted;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= sampleAddr;
    end

    // The RAM word for s1 misses two writes: the one in the write stage now
    // and the one that landed in the cycle the read was issued.
    always_comb begin
        if (wrQ.en && (wrQ.addr.flat == s1Addr.flat)) begin
            base = wrQ.data;
        end else if (prevWr.en && (prevWr.addr.flat == s1Addr.flat)) begin
            base = prevWr.data;
        end else begin
            base = ramRdData;
        end
        incCount = (base == '1) ? base : base + 1'b1;   // saturate at all ones
    end

    always_comb begin
        wrNext.en   = s1Valid;
        wrNext.addr = s1Addr;
        wrNext.data = incCount;
        if (ctrl.clearEn) begin
            wrNext.en        = 1'b1;
            wrNext.addr.flat = clearAddr;        // sweep address, zero data
            wrNext.data      = '0;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrQ    <= '0;
            prevWr <= '0;
        end else begin
            wrQ    <= wrNext;
            prevWr <= wrQ;
        end
    end

    assign wr = wrQ;

endmodule

// ==== src/histFsm.sv ====
`timescale 1ns/10ps

module histFsm import histCtrlPkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      start,
    input  logic      clearLast,
    input  logic      acqLast,
    input  logic      accepted,
    output histCtrl_t ctrl,
    output logic      clearLoad,
    output logic      clearEn,
    output logic      acqLoad,
    output logic      ready,
    output logic      busy,
    output logic      done
);

    histState_t state;
    histState_t nextState;
    logic       sweepDone;                       // last clear address issued
    logic       drainCnt;                        // high in the second drain cycle

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= CLEAR;
        end else begin
            state <= nextState;
        end
    end

    // clear writes lag the sweep by one cycle in the write stage,
    // so CLEAR is held until that last write has gone out
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweepDone <= 1'b0;
        end else if (clearEn && clearLast) begin
            sweepDone <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            drainCnt <= 1'b0;
        end else if (state == DRAIN) begin
            drainCnt <= ~drainCnt;
        end else begin
            drainCnt <= 1'b0;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            CLEAR: begin
                if (sweepDone) begin
                    nextState = IDLE;
                end
            end
            IDLE: begin
                if (start) begin
                    nextState = ACQ;
                end
            end
            ACQ: begin
                if (accepted && acqLast) begin   // final sample of the run
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (drainCnt) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = CLEAR;
            end
        endcase
    end

    assign clearEn   = (state == CLEAR) && !sweepDone;
    assign clearLoad = (state == CLEAR) && sweepDone;   // park the sweep address
    assign acqLoad   = (state == IDLE) && start;

    assign ctrl.accept  = (state == ACQ);
    assign ctrl.clearEn = clearEn;
    assign ctrl.rdGrant = (state == IDLE);

    assign ready = (state == IDLE);
    assign busy  = (state == ACQ) || (state == DRAIN);
    assign done  = (state == DONE);

endmodule

// ==== src/sifhTop.sv ====
`timescale 1ns/10ps
`include "hist_defs.svh"

module sifhTop import histDataPkg::*, histCtrlPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     start,
    input  logic     sampleValid,
    input  sample_t  sample,
    input  logic     rdEn,
    input  ramAddr_u rdAddr,
    output logic     ready,
    output logic     busy,
    output logic     done,
    output count_t   rdData
);

    histCtrl_t          ctrl;
    logic               clearLoad;
    logic               clearEn;
    logic               clearLast;
    logic               acqLoad;
    logic               acqLast;
    logic               accepted;
    logic [`ADDR_W-1:0] clearAddr;
    ramAddr_u           ramRdAddr;
    ramWr_t             ramWr;

    histFsm fsm (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .clearLast (clearLast),
        .acqLast   (acqLast),
        .accepted  (accepted),
        .ctrl      (ctrl),
        .clearLoad (clearLoad),
        .clearEn   (clearEn),
        .acqLoad   (acqLoad),
        .ready     (ready),
        .busy      (busy),
        .done      (done)
    );

    // sweeps every RAM word once after reset
    sampleCounter #(
        .Width    (`ADDR_W),
        .Terminal (`RAM_WORDS)
    ) clearCnt (
        .clk    (clk),
        .res    (res),
        .load   (clearLoad),
        .enable (clearEn),
        .value  (clearAddr),
        .last   (clearLast)
    );

    // accepted samples of the running acquisition
    sampleCounter #(
        .Width    (`ACQ_W),
        .Terminal (`ACQ_LEN)
    ) acqCnt (
        .clk    (clk),
        .res    (res),
        .load   (acqLoad),
        .enable (accepted),
        .value  (),
        .last   (acqLast)
    );

    histAccum accum (
        .clk         (clk),
        .res         (res),
        .ctrl        (ctrl),
        .sampleValid (sampleValid),
        .sample      (sample),
        .clearAddr   (clearAddr),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .ramRdAddr   (ramRdAddr),
        .ramRdData   (rdData),
        .wr          (ramWr),
        .accepted    (accepted)
    );

    // read data feeds both the accumulator and the readout port
    binRam ram (
        .clk    (clk),
        .wr     (ramWr),
        .rdAddr (ramRdAddr),
        .rdData (rdData)
    );

endmodule

// ==== dv/sifh_props.sv ====
`timescale 1ns/10ps

module sifhProps import histDataPkg::*; (
    input logic   clk,
    input logic   res,
    input logic   ready,
    input logic   busy,
    input logic   done,
    input ramWr_t wr
);

    // done marks the end of one acquisition only
    donePulse: assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // ready is high exactly in idle, where the RAM is only read
    noWriteIdle: assert property (@(posedge clk) disable iff (!res) ready |-> !wr.en)
        else $error("RAM write enable high while idle");

    readyBusy: assert property (@(posedge clk) disable iff (!res) !(ready && busy))
        else $error("ready and busy high together");

endmodule

// ==== dv/sifhChecker.sv ====
`timescale 1ns/10ps
`include "hist_defs.svh"

module sifhChecker import histDataPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     start,
    input  logic     sampleValid,
    input  sample_t  sample,
    input  logic     rdEn,
    input  ramAddr_u rdAddr,
    input  logic     ready,
    input  logic     busy,
    input  logic     done,
    input  count_t   rdData,
    input  int       testId,
    input  logic     testEnd,
    output int       errCount,
    output int       testsRun,
    output int       testsFailed
);

    count_t             model [`RAM_WORDS];      // expected histogram
    logic               cleared     = 1'b0;
    logic               acqActive   = 1'b0;
    int                 acqCount    = 0;
    int                 doneWait    = 0;         // edges left until done is due
    int                 clearCycles = 0;
    logic               rdPending   = 1'b0;
    logic [`ADDR_W-1:0] rdPendAddr  = '0;
    int                 errs        = 0;
    int                 testErrs    = 0;
    int                 runCnt      = 0;
    int                 failCnt     = 0;

    assign errCount    = errs;
    assign testsRun    = runCnt;
    assign testsFailed = failCnt;

    function automatic string testName(input int id);
        case (id)
            1:       return "clear";
            2:       return "random";
            3:       return "forwarding";
            4:       return "saturation";
            5:       return "ignored";
            default: return "setup";
        endcase
    endfunction

    task automatic valueFail(input string what, input int expVal, input int actVal);
        $display("[FAIL] %s: %s expected %0d actual %0d",
                 testName(testId), what, expVal, actVal);
        errs++;
        testErrs++;
    endtask

    task automatic ruleFail(input string what);
        $display("%s: %s", testName(testId), what);
        errs++;
        testErrs++;
    endtask

    // all values seen here are the ones before the edge
    always @(posedge clk) begin : watch
        logic [`ADDR_W-1:0] wordAddr;
        int                 flatIdx;
        logic               expReady;
        logic               expBusy;
        logic               expDone;
        expReady = 1'b0;
        if (!res) begin
            model       = '{default: '0};
            cleared     = 1'b0;
            acqActive   = 1'b0;
            doneWait    = 0;
            clearCycles = 0;
            rdPending   = 1'b0;
            if (ready || busy || done) begin
                ruleFail("a control output is high during reset");
            end
        end else begin
            if (rdPending && (rdData !== model[rdPendAddr])) begin
                valueFail($sformatf("rdData of word %0d", rdPendAddr),
                          int'(model[rdPendAddr]), int'(rdData));
            end
            if (!cleared) begin
                if (busy || done) begin
                    ruleFail("busy or done went high while the RAM was cleared");
                end
                if (ready) begin
                    cleared = 1'b1;
                    // one cycle per word, then the last write leaves the write stage
                    if (clearCycles != `RAM_WORDS + 1) begin
                        valueFail("clear cycles", `RAM_WORDS + 1, clearCycles);
                    end
                end else begin
                    clearCycles++;
                end
            end
            if (cleared) begin
                expBusy  = acqActive || (doneWait >= 2);   // ACQ and both drain cycles
                expDone  = (doneWait == 1);
                expReady = !acqActive && (doneWait == 0);
                if (busy !== expBusy) begin
                    valueFail("busy", int'(expBusy), int'(busy));
                end
                if (done !== expDone) begin
                    valueFail("done", int'(expDone), int'(done));
                end
                if (ready !== expReady) begin
                    valueFail("ready", int'(expReady), int'(ready));
                end
                if (doneWait > 0) begin
                    doneWait--;
                end
                if (expReady && start) begin
                    acqActive = 1'b1;
                    acqCount  = 0;
                end else if (acqActive && sampleValid) begin
                    flatIdx  = int'(sample.pix) * `BIN_NUM + int'(sample.bin);
                    wordAddr = flatIdx[`ADDR_W-1:0];
                    if (model[wordAddr] != '1) begin
                        model[wordAddr] = model[wordAddr] + 1'b1;
                    end
                    acqCount++;
                    if (acqCount == `ACQ_LEN) begin
                        acqActive = 1'b0;
                        doneWait  = 3;           // two drain cycles, then DONE
                    end
                end
            end
            rdPending  = expReady && rdEn;
            rdPendAddr = rdAddr.flat;
        end
        if (testEnd) begin
            if (testErrs == 0) begin
                $display("test %s: ok", testName(testId));
            end else begin
                $display("test %s: failed with %0d errors", testName(testId), testErrs);
                failCnt++;
            end
            runCnt++;
            testErrs = 0;
        end
    end

endmodule

// ==== dv/sifhTb.sv ====
`timescale 1ns/10ps
`include "hist_defs.svh"

module sifhTb import histDataPkg::*; ();

    logic        clk;
    logic        res;
    logic        start;
    logic        sampleValid;
    sample_t     sample;
    logic        rdEn;
    ramAddr_u    rdAddr;
    logic        ready;
    logic        busy;
    logic        done;
    count_t      rdData;
    int          testId;
    logic        testEnd;
    int          errCount;
    int          testsRun;
    int          testsFailed;
    logic [31:0] lcgState;

    sifhTop UUT (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sampleValid (sampleValid),
        .sample      (sample),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .ready       (ready),
        .busy        (busy),
        .done        (done),
        .rdData      (rdData)
    );

    sifhChecker chk (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sampleValid (sampleValid),
        .sample      (sample),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .ready       (ready),
        .busy        (busy),
        .done        (done),
        .rdData      (rdData),
        .testId      (testId),
        .testEnd     (testEnd),
        .errCount    (errCount),
        .testsRun    (testsRun),
        .testsFailed (testsFailed)
    );

    bind sifhTop sifhProps props (
        .clk   (clk),
        .res   (res),
        .ready (ready),
        .busy  (busy),
        .done  (done),
        .wr    (ramWr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                       // 100 ns period

    function automatic logic [31:0] randomWord();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // to the next drive point 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic applyReset();
        res = 1'b0;
        repeat (5) step();
        res = 1'b1;
    endtask

    task automatic finishRun(input logic timedOut);
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 testsRun, testsFailed, errCount);
        if (!timedOut && (errCount == 0) && (testsFailed == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout: no %s within the allowed cycles", what);
        finishRun(1'b1);
    endtask

    task automatic waitReady();
        int cycles;
        for (cycles = 0; (cycles < 4 * `RAM_WORDS) && !ready; cycles++) begin
            step();
        end
        if (!ready) begin
            timeoutFail("ready after reset");
        end
    endtask

    task automatic readAll();
        for (int a = 0; a < `RAM_WORDS; a++) begin
            rdEn        = 1'b1;
            rdAddr.flat = a[`ADDR_W-1:0];
            step();
        end
        rdEn = 1'b0;
        step();                                  // last word returns here
    endtask

    task automatic endTest();
        testEnd = 1'b1;
        step();
        testEnd = 1'b0;
    endtask

    // samples in idle must not count
    task automatic idleSamples(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r           = randomWord();
            sampleValid = 1'b1;
            sample      = r[`ADDR_W+7:8];
            step();
        end
        sampleValid = 1'b0;
    endtask

    // 0 random, 1 runs on one word, 2 one hot bin, 3 with stray start and rdEn
    task automatic runAcq(input int mode);
        logic [31:0] r;
        sample_t     cur;
        int          runLeft;
        int          cycles;
        logic        seen;
        cur     = '0;
        runLeft = 0;
        seen    = 1'b0;
        start   = 1'b1;
        step();
        for (cycles = 0; (cycles < 3 * `ACQ_LEN) && !seen; cycles++) begin
            r           = randomWord();
            start       = 1'b0;
            rdEn        = 1'b0;
            sampleValid = (r[31:24] < 8'd179);   // about 70 percent
            sample      = r[`ADDR_W+7:8];
            if (mode == 1) begin
                if (runLeft == 0) begin
                    cur     = r[`ADDR_W+7:8];
                    runLeft = (cycles == 0) ? 40 : 1 + int'(r[18:16]);
                end
                sampleValid = (r[31:24] < 8'd218);   // the odd gap hits the older write
                sample      = cur;
                if (sampleValid) begin
                    runLeft--;
                end
            end else if (mode == 2) begin
                if (r[2:0] != 3'd0) begin
                    sample.pix = pixIdx_t'(2);
                    sample.bin = binIdx_t'(9);
                end
            end else if (mode == 3) begin
                start       = r[7];
                rdEn        = r[6];
                rdAddr.flat = r[`ADDR_W+15:16];
            end
            step();
            seen = done;
        end
        start       = 1'b0;
        sampleValid = 1'b0;
        rdEn        = 1'b0;
        if (!seen) begin
            timeoutFail("done pulse after start");
        end
        step();                                  // DONE back to IDLE
    endtask

    initial begin
        res         = 1'b0;
        start       = 1'b0;
        sampleValid = 1'b0;
        sample      = '0;
        rdEn        = 1'b0;
        rdAddr      = '0;
        testId      = 0;
        testEnd     = 1'b0;
        lcgState    = 32'ha252b0ff;
        applyReset();

        testId = 1;
        waitReady();
        readAll();                               // every word zero after the sweep
        endTest();

        testId = 2;
        runAcq(0);
        readAll();
        endTest();

        testId = 3;
        runAcq(1);
        readAll();
        endTest();

        testId = 4;
        runAcq(2);
        runAcq(2);                               // second run pushes the hot bin to the limit
        readAll();
        endTest();

        testId = 5;
        idleSamples(20);
        runAcq(3);
        readAll();
        endTest();

        // a second reset has to wipe the counts left by the runs
        testId = 1;
        applyReset();
        waitReady();
        readAll();
        endTest();

        finishRun(1'b0);
    end

endmodule

// ==== sifhTop.f ====
+incdir+include
src/histDataPkg.sv
src/histCtrlPkg.sv
src/binRam.sv
src/sampleCounter.sv
src/histAccum.sv
src/histFsm.sv
src/sifhTop.sv
dv/sifh_props.sv
dv/sifhChecker.sv
dv/sifhTb.sv

// ==== Makefile ====
SRCS = $(wildcard src/*.sv dv/*.sv include/*.svh) sifhTop.f

.PHONY: all run clean

all: run

obj_dir/VsifhTb: $(SRCS)
	verilator --binary --timing --assert -f sifhTop.f --top-module sifhTb -Mdir obj_dir

run: obj_dir/VsifhTb
	./obj_dir/VsifhTb | tee sim.log
	grep -qx "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
